// ==== common/cache_bus_pkg.sv ====
/* cache bus package: widths, queue depths, request, return and bus
   structs shared by the cache-to-bus bridge */
package cache_bus_pkg;

  ////////////////////
  // sizes
  ////////////////////
  localparam int unsigned PLEN              = 32;
  localparam int unsigned WORD_WIDTH        = 64;
  localparam int unsigned ICACHE_LINE_WORDS = 4;
  localparam int unsigned DCACHE_LINE_WORDS = 2;
  localparam int unsigned MAX_LINE_WORDS    =
      (ICACHE_LINE_WORDS > DCACHE_LINE_WORDS) ? ICACHE_LINE_WORDS : DCACHE_LINE_WORDS;
  // burst length is beats minus one
  localparam int unsigned BLEN_WIDTH        = $clog2(MAX_LINE_WORDS);
  localparam int unsigned TID_WIDTH         = 2;
  localparam int unsigned REQ_FIFO_DEPTH    = 2;
  localparam int unsigned META_FIFO_DEPTH   = 4;

  localparam logic BUS_ID_ICACHE = 1'b0;
  localparam logic BUS_ID_DCACHE = 1'b1;

  typedef logic [ICACHE_LINE_WORDS-1:0][WORD_WIDTH-1:0] icache_line_t;
  typedef logic [DCACHE_LINE_WORDS-1:0][WORD_WIDTH-1:0] dcache_line_t;

  ////////////////////
  // cache side
  ////////////////////
  typedef struct packed {
    logic [PLEN-1:0]      paddr;
    logic                 nc;
    logic [TID_WIDTH-1:0] tid;
  } icache_req_t;

  typedef struct packed {
    logic [TID_WIDTH-1:0] tid;
    icache_line_t         data;
  } icache_rtrn_t;

  typedef enum logic {
    DCACHE_LOAD_REQ,
    DCACHE_STORE_REQ
  } dcache_req_e;

  // size[2] requests a full line
  typedef struct packed {
    dcache_req_e           rtype;
    logic [PLEN-1:0]       paddr;
    logic [2:0]            size;
    logic [TID_WIDTH-1:0]  tid;
    logic [WORD_WIDTH-1:0] data;
  } dcache_req_t;

  typedef enum logic {
    DCACHE_LOAD_ACK,
    DCACHE_STORE_ACK
  } dcache_rtrn_e;

  typedef struct packed {
    dcache_rtrn_e         rtype;
    logic [TID_WIDTH-1:0] tid;
    dcache_line_t         data;
  } dcache_rtrn_t;

  ////////////////////
  // bus side
  ////////////////////
  typedef struct packed {
    logic [PLEN-1:0]       addr;
    logic [BLEN_WIDTH-1:0] blen;
    logic [1:0]            size;
    logic                  id;
  } bus_rd_req_t;

  typedef struct packed {
    logic [PLEN-1:0]       addr;
    logic [WORD_WIDTH-1:0] data;
    logic [7:0]            be;
    logic [1:0]            size;
    logic                  id;
  } bus_wr_req_t;

  typedef struct packed {
    logic [WORD_WIDTH-1:0] data;
    logic                  id;
    logic                  last;
  } bus_rd_beat_t;

  // 2**size byte lanes starting at the address offset
  function automatic logic [7:0] to_byte_enable8(input logic [2:0] offset,
                                                 input logic [1:0] size);
    logic [8:0] mask;
    mask = (9'd1 << (4'd1 << size)) - 9'd1;
    return mask[7:0] << offset;
  endfunction

endpackage

// ==== verilog/id_fifo.sv ====
/* small register-array FIFO with a fill count, used for requests,
   transaction ids and write responses */
`timescale 1ns/1ns

module id_fifo #(
  parameter int unsigned WIDTH = 2,
  parameter int unsigned DEPTH = 4
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             push_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] data_o,
  output logic             full_o,
  output logic             empty_o
);

  logic [DEPTH-1:0][WIDTH-1:0] mem_q;
  logic [$clog2(DEPTH)-1:0]    wr_ptr_q, rd_ptr_q;
  logic [$clog2(DEPTH+1)-1:0]  cnt_q;
  logic                        do_push, do_pop;

  assign full_o  = (cnt_q == DEPTH);
  assign empty_o = (cnt_q == 0);
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  // pointers wrap at DEPTH, so depths other than powers of two work
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (do_pop && !do_push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// ==== icache_path/icache_path.sv ====
/* instruction cache path: request queue, in-order tid tracking and
   assembly of read beats into registered line returns */
`timescale 1ns/1ns

module icache_path import cache_bus_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  // cache side
  input  logic         icache_req_i,
  input  icache_req_t  icache_data_i,
  output logic         icache_ack_o,
  output logic         icache_rtrn_vld_o,
  output icache_rtrn_t icache_rtrn_o,
  // arbiter side
  output logic         rd_req_vld_o,
  output bus_rd_req_t  rd_req_o,
  input  logic         gnt_i,
  input  logic         beat_vld_i,
  input  bus_rd_beat_t beat_i
);

  icache_req_t          req_head;
  logic                 req_full, req_empty;
  logic [TID_WIDTH-1:0] tid_head;
  logic                 tid_full;
  logic                 last_beat;
  logic                 first_q;
  logic                 rtrn_vld_q;
  logic [TID_WIDTH-1:0] rtrn_tid_q;
  icache_line_t         line_d, line_q;

  ////////////////////
  // request side
  ////////////////////
  assign icache_ack_o = icache_req_i & ~req_full;

  id_fifo #(
    .WIDTH ($bits(icache_req_t)),
    .DEPTH (REQ_FIFO_DEPTH)
  ) i_req_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (icache_ack_o),
    .data_i  (icache_data_i),
    .pop_i   (gnt_i),
    .data_o  (req_head),
    .full_o  (req_full),
    .empty_o (req_empty)
  );

  // one tid per granted fill, popped by its last beat
  id_fifo #(
    .WIDTH (TID_WIDTH),
    .DEPTH (META_FIFO_DEPTH)
  ) i_tid_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (gnt_i),
    .data_i  (req_head.tid),
    .pop_i   (last_beat),
    .data_o  (tid_head),
    .full_o  (tid_full),
    .empty_o ()
  );

  assign rd_req_vld_o = ~req_empty & ~tid_full;

  // fetches are always 64 bit words, the bus id is stamped by the arbiter
  always_comb begin
    rd_req_o      = '0;
    rd_req_o.addr = req_head.paddr;
    rd_req_o.size = 2'b11;
    if (!req_head.nc) begin
      rd_req_o.blen = BLEN_WIDTH'(ICACHE_LINE_WORDS - 1);
    end
  end

  ////////////////////
  // return side
  ////////////////////
  assign last_beat = beat_vld_i & beat_i.last;

  // beats shift in from the top, a single word lands on word 0
  always_comb begin
    line_d = {beat_i.data, line_q[ICACHE_LINE_WORDS-1:1]};
    if (first_q) begin
      line_d[0] = beat_i.data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_q    <= 1'b1;
      rtrn_vld_q <= 1'b0;
    end else begin
      if (beat_vld_i) begin
        first_q <= beat_i.last;
      end
      rtrn_vld_q <= last_beat;
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat_vld_i) begin
      line_q <= line_d;
    end
    if (last_beat) begin
      rtrn_tid_q <= tid_head;
    end
  end

  assign icache_rtrn_vld_o  = rtrn_vld_q;
  assign icache_rtrn_o.tid  = rtrn_tid_q;
  assign icache_rtrn_o.data = line_q;

endmodule

// ==== dcache_path/dcache_path.sv ====
/* data cache path: request queue, read and write tid tracking, write
   response buffer and load line assembly */
`timescale 1ns/1ns

module dcache_path import cache_bus_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  // cache side
  input  logic         dcache_req_i,
  input  dcache_req_t  dcache_data_i,
  output logic         dcache_ack_o,
  output logic         dcache_rtrn_vld_o,
  output dcache_rtrn_t dcache_rtrn_o,
  // arbiter side
  output logic         rd_req_vld_o,
  output bus_rd_req_t  rd_req_o,
  output logic         wr_req_vld_o,
  output bus_wr_req_t  wr_req_o,
  input  logic         gnt_i,
  input  logic         beat_vld_i,
  input  bus_rd_beat_t beat_i,
  // write responses
  input  logic         b_valid_i,
  input  logic         b_id_i,
  output logic         b_ready_o
);

  dcache_req_t          req_head;
  logic                 req_full, req_empty;
  logic                 is_store;
  logic [TID_WIDTH-1:0] rd_tid, wr_tid;
  logic                 rd_tid_full, wr_tid_full;
  logic                 rd_pop, wr_pop;
  logic                 b_full, b_empty, b_pop, b_id;
  logic                 first_q;
  logic                 rtrn_vld_d, rtrn_vld_q;
  dcache_rtrn_e         rtrn_type_d, rtrn_type_q;
  logic [TID_WIDTH-1:0] rtrn_tid_d, rtrn_tid_q;
  dcache_line_t         line_d, line_q;

  ////////////////////
  // request side
  ////////////////////
  assign dcache_ack_o = dcache_req_i & ~req_full;
  assign is_store     = (req_head.rtype == DCACHE_STORE_REQ);

  id_fifo #(
    .WIDTH ($bits(dcache_req_t)),
    .DEPTH (REQ_FIFO_DEPTH)
  ) i_req_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (dcache_ack_o),
    .data_i  (dcache_data_i),
    .pop_i   (gnt_i),
    .data_o  (req_head),
    .full_o  (req_full),
    .empty_o (req_empty)
  );

  // loads and stores complete independently, so each keeps its own order
  id_fifo #(
    .WIDTH (TID_WIDTH),
    .DEPTH (META_FIFO_DEPTH)
  ) i_rd_tid_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (gnt_i & ~is_store),
    .data_i  (req_head.tid),
    .pop_i   (rd_pop),
    .data_o  (rd_tid),
    .full_o  (rd_tid_full),
    .empty_o ()
  );

  id_fifo #(
    .WIDTH (TID_WIDTH),
    .DEPTH (META_FIFO_DEPTH)
  ) i_wr_tid_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (gnt_i & is_store),
    .data_i  (req_head.tid),
    .pop_i   (wr_pop),
    .data_o  (wr_tid),
    .full_o  (wr_tid_full),
    .empty_o ()
  );

  assign rd_req_vld_o = ~req_empty & ~is_store & ~rd_tid_full;
  assign wr_req_vld_o = ~req_empty & is_store & ~wr_tid_full;

  // bus ids are left zero here and stamped by the arbiter
  always_comb begin
    rd_req_o      = '0;
    rd_req_o.addr = req_head.paddr;
    rd_req_o.size = req_head.size[1:0];
    if (req_head.size[2]) begin
      rd_req_o.blen = BLEN_WIDTH'(DCACHE_LINE_WORDS - 1);
    end
    wr_req_o      = '0;
    wr_req_o.addr = req_head.paddr;
    wr_req_o.data = req_head.data;
    wr_req_o.size = req_head.size[1:0];
    wr_req_o.be   = to_byte_enable8(req_head.paddr[2:0], req_head.size[1:0]);
  end

  ////////////////////
  // return side
  ////////////////////
  assign b_ready_o = ~b_full;

  id_fifo #(
    .WIDTH (1),
    .DEPTH (META_FIFO_DEPTH)
  ) i_b_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (b_valid_i),
    .data_i  (b_id_i),
    .pop_i   (b_pop),
    .data_o  (b_id),
    .full_o  (b_full),
    .empty_o (b_empty)
  );

  // read beats win, a buffered write response goes out on a free cycle
  always_comb begin
    line_d      = {beat_i.data, line_q[DCACHE_LINE_WORDS-1:1]};
    rd_pop      = 1'b0;
    wr_pop      = 1'b0;
    b_pop       = 1'b0;
    rtrn_vld_d  = 1'b0;
    rtrn_type_d = DCACHE_LOAD_ACK;
    rtrn_tid_d  = rd_tid;
    if (first_q) begin
      line_d[0] = beat_i.data;
    end
    if (beat_vld_i) begin
      rd_pop     = beat_i.last;
      rtrn_vld_d = beat_i.last;
    end else if (!b_empty) begin
      b_pop = 1'b1;
      // a response carrying a foreign id is dropped
      if (b_id == BUS_ID_DCACHE) begin
        wr_pop      = 1'b1;
        rtrn_vld_d  = 1'b1;
        rtrn_type_d = DCACHE_STORE_ACK;
        rtrn_tid_d  = wr_tid;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_q    <= 1'b1;
      rtrn_vld_q <= 1'b0;
    end else begin
      if (beat_vld_i) begin
        first_q <= beat_i.last;
      end
      rtrn_vld_q <= rtrn_vld_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat_vld_i) begin
      line_q <= line_d;
    end
    if (rtrn_vld_d) begin
      rtrn_type_q <= rtrn_type_d;
      rtrn_tid_q  <= rtrn_tid_d;
    end
  end

  assign dcache_rtrn_vld_o   = rtrn_vld_q;
  assign dcache_rtrn_o.rtype = rtrn_type_q;
  assign dcache_rtrn_o.tid   = rtrn_tid_q;
  assign dcache_rtrn_o.data  = line_q;

endmodule

// ==== verilog/bus_arbiter.sv ====
/* round-robin bus arbiter that locks its choice until the grant and
   routes read beats back by bus id */
`timescale 1ns/1ns

module bus_arbiter import cache_bus_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  // path requests
  input  logic         ic_rd_vld_i,
  input  bus_rd_req_t  ic_rd_i,
  input  logic         dc_rd_vld_i,
  input  bus_rd_req_t  dc_rd_i,
  input  logic         dc_wr_vld_i,
  input  bus_wr_req_t  dc_wr_i,
  output logic         ic_gnt_o,
  output logic         dc_gnt_o,
  // beats back to the paths
  output logic         ic_beat_vld_o,
  output logic         dc_beat_vld_o,
  output bus_rd_beat_t beat_o,
  // bus
  output logic         bus_rd_req_o,
  output bus_rd_req_t  bus_rd_o,
  input  logic         bus_rd_gnt_i,
  output logic         bus_wr_req_o,
  output bus_wr_req_t  bus_wr_o,
  input  logic         bus_wr_gnt_i,
  input  logic         bus_rd_valid_i,
  input  bus_rd_beat_t bus_rd_beat_i
);

  logic ic_req, dc_req;
  logic sel, gnt;
  // prio_q points at the preferred path, and at the held path while locked
  logic lock_q, prio_q;

  assign ic_req = ic_rd_vld_i;
  assign dc_req = dc_rd_vld_i | dc_wr_vld_i;

  ////////////////////
  // selection
  ////////////////////
  // sel high picks the dcache path
  assign sel = (lock_q || (ic_req && dc_req)) ? prio_q : dc_req;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lock_q <= 1'b0;
      prio_q <= 1'b0;
    end else if (gnt) begin
      lock_q <= 1'b0;
      prio_q <= ~sel;
    end else if (ic_req || dc_req) begin
      lock_q <= 1'b1;
      prio_q <= sel;
    end
  end

  ////////////////////
  // bus drive
  ////////////////////
  assign bus_rd_req_o = sel ? dc_rd_vld_i : ic_rd_vld_i;
  assign bus_wr_req_o = sel & dc_wr_vld_i;

  always_comb begin
    bus_rd_o    = sel ? dc_rd_i : ic_rd_i;
    bus_rd_o.id = sel ? BUS_ID_DCACHE : BUS_ID_ICACHE;
    bus_wr_o    = dc_wr_i;
    bus_wr_o.id = BUS_ID_DCACHE;
  end

  assign gnt      = (bus_rd_req_o & bus_rd_gnt_i) | (bus_wr_req_o & bus_wr_gnt_i);
  assign ic_gnt_o = gnt & ~sel;
  assign dc_gnt_o = gnt & sel;

  ////////////////////
  // beat routing
  ////////////////////
  assign beat_o        = bus_rd_beat_i;
  assign ic_beat_vld_o = bus_rd_valid_i & (bus_rd_beat_i.id == BUS_ID_ICACHE);
  assign dc_beat_vld_o = bus_rd_valid_i & (bus_rd_beat_i.id == BUS_ID_DCACHE);

endmodule

// ==== verilog/cache_bus_adapter.sv ====
/* cache bus adapter: joins the instruction and data cache paths to one
   split read/write memory bus through the arbiter */
`timescale 1ns/1ns

module cache_bus_adapter import cache_bus_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  // instruction cache
  input  logic         icache_req_i,
  input  icache_req_t  icache_data_i,
  output logic         icache_ack_o,
  output logic         icache_rtrn_vld_o,
  output icache_rtrn_t icache_rtrn_o,
  // data cache
  input  logic         dcache_req_i,
  input  dcache_req_t  dcache_data_i,
  output logic         dcache_ack_o,
  output logic         dcache_rtrn_vld_o,
  output dcache_rtrn_t dcache_rtrn_o,
  // memory bus
  output logic         bus_rd_req_o,
  output bus_rd_req_t  bus_rd_o,
  input  logic         bus_rd_gnt_i,
  output logic         bus_wr_req_o,
  output bus_wr_req_t  bus_wr_o,
  input  logic         bus_wr_gnt_i,
  input  logic         bus_rd_valid_i,
  input  bus_rd_beat_t bus_rd_beat_i,
  input  logic         bus_b_valid_i,
  input  logic         bus_b_id_i,
  output logic         bus_b_ready_o
);

  logic         ic_rd_vld, dc_rd_vld, dc_wr_vld;
  bus_rd_req_t  ic_rd, dc_rd;
  bus_wr_req_t  dc_wr;
  logic         ic_gnt, dc_gnt;
  logic         ic_beat_vld, dc_beat_vld;
  bus_rd_beat_t beat;

  icache_path i_icache_path (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .icache_req_i      (icache_req_i),
    .icache_data_i     (icache_data_i),
    .icache_ack_o      (icache_ack_o),
    .icache_rtrn_vld_o (icache_rtrn_vld_o),
    .icache_rtrn_o     (icache_rtrn_o),
    .rd_req_vld_o      (ic_rd_vld),
    .rd_req_o          (ic_rd),
    .gnt_i             (ic_gnt),
    .beat_vld_i        (ic_beat_vld),
    .beat_i            (beat)
  );

  dcache_path i_dcache_path (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .dcache_req_i      (dcache_req_i),
    .dcache_data_i     (dcache_data_i),
    .dcache_ack_o      (dcache_ack_o),
    .dcache_rtrn_vld_o (dcache_rtrn_vld_o),
    .dcache_rtrn_o     (dcache_rtrn_o),
    .rd_req_vld_o      (dc_rd_vld),
    .rd_req_o          (dc_rd),
    .wr_req_vld_o      (dc_wr_vld),
    .wr_req_o          (dc_wr),
    .gnt_i             (dc_gnt),
    .beat_vld_i        (dc_beat_vld),
    .beat_i            (beat),
    .b_valid_i         (bus_b_valid_i),
    .b_id_i            (bus_b_id_i),
    .b_ready_o         (bus_b_ready_o)
  );

  bus_arbiter i_bus_arbiter (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ic_rd_vld_i    (ic_rd_vld),
    .ic_rd_i        (ic_rd),
    .dc_rd_vld_i    (dc_rd_vld),
    .dc_rd_i        (dc_rd),
    .dc_wr_vld_i    (dc_wr_vld),
    .dc_wr_i        (dc_wr),
    .ic_gnt_o       (ic_gnt),
    .dc_gnt_o       (dc_gnt),
    .ic_beat_vld_o  (ic_beat_vld),
    .dc_beat_vld_o  (dc_beat_vld),
    .beat_o         (beat),
    .bus_rd_req_o   (bus_rd_req_o),
    .bus_rd_o       (bus_rd_o),
    .bus_rd_gnt_i   (bus_rd_gnt_i),
    .bus_wr_req_o   (bus_wr_req_o),
    .bus_wr_o       (bus_wr_o),
    .bus_wr_gnt_i   (bus_wr_gnt_i),
    .bus_rd_valid_i (bus_rd_valid_i),
    .bus_rd_beat_i  (bus_rd_beat_i)
  );

endmodule

// ==== verif/tb_cache_bus_adapter.sv ====
/* testbench for the cache bus adapter with a bus memory model, random
   grant delays and in-order return checking */
`timescale 1ns/1ns

module tb_cache_bus_adapter import cache_bus_pkg::*; ();

  localparam int unsigned MAX_TRANS = 64;
  localparam int unsigned STIM_COLS = 6;
  localparam logic [1:0]  OP_IFILL  = 2'd0;
  localparam logic [1:0]  OP_IFETCH = 2'd1;
  localparam logic [1:0]  OP_DLOAD  = 2'd2;
  localparam logic [1:0]  OP_DSTORE = 2'd3;

  typedef struct packed {
    logic [7:0]            idx;
    logic [1:0]            op;
    logic [PLEN-1:0]       addr;
    logic [2:0]            size;
    logic [TID_WIDTH-1:0]  tid;
    logic [WORD_WIDTH-1:0] data;
    logic [WORD_WIDTH-1:0] exp_val;
  } trans_t;

  logic         clk_i          = 1'b0;
  logic         rst_ni         = 1'b0;
  logic         icache_req_i   = 1'b0;
  icache_req_t  icache_data_i  = '0;
  logic         dcache_req_i   = 1'b0;
  dcache_req_t  dcache_data_i  = '0;
  logic         bus_rd_gnt_i   = 1'b0;
  logic         bus_wr_gnt_i   = 1'b0;
  logic         bus_rd_valid_i = 1'b0;
  bus_rd_beat_t bus_rd_beat_i  = '0;
  logic         bus_b_valid_i  = 1'b0;
  logic         bus_b_id_i     = 1'b0;
  logic         icache_ack_o, icache_rtrn_vld_o;
  icache_rtrn_t icache_rtrn_o;
  logic         dcache_ack_o, dcache_rtrn_vld_o;
  dcache_rtrn_t dcache_rtrn_o;
  logic         bus_rd_req_o, bus_wr_req_o, bus_b_ready_o;
  bus_rd_req_t  bus_rd_o;
  bus_wr_req_t  bus_wr_o;

  logic [63:0]  stim_raw [0:STIM_COLS*MAX_TRANS-1];
  trans_t       stim [0:MAX_TRANS-1];
  int           n_trans = 0;
  int           errors = 0;
  int           ic_acked = 0, dc_acked = 0, ic_rtrn_cnt = 0, dc_rtrn_cnt = 0;
  trans_t       ic_q[$], ld_q[$], st_bus_q[$], st_ack_q[$];
  trans_t       ic_rd_q[$], dc_rd_q[$];
  bus_rd_req_t  rd_q[$];
  logic         b_q[$];
  logic [15:0]  lfsr = 16'd48;
  int           gnt_wait = 0;
  int           beat_cnt = 0;
  // last beats taken at the previous rising edge
  logic         ic_last_q = 1'b0;
  logic         dc_last_q = 1'b0;

  cache_bus_adapter dut (.*);

  always #5 clk_i = ~clk_i;

  ////////////////////
  // helpers
  ////////////////////
  // 8-byte word at address a holds a above and ~a below
  function automatic logic [63:0] mem_word(input logic [PLEN-1:0] a);
    logic [PLEN-1:0] base;
    base = {a[PLEN-1:3], 3'b000};
    return {base, ~base};
  endfunction

  // galois lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output int val);
    val = 0;
    for (int b = 0; b < n; b++) begin
      val  = (val << 1) | int'(lfsr[0]);
      lfsr = lfsr_next(lfsr);
    end
  endtask

  function automatic string test_name(input trans_t t);
    string kind;
    case (t.op)
      OP_IFILL:  kind = "ifill";
      OP_IFETCH: kind = "ifetch";
      OP_DLOAD:  kind = "dload";
      default:   kind = "dstore";
    endcase
    return $sformatf("%s_%0d", kind, t.idx);
  endfunction

  task automatic report_mismatch(input string name, input string field,
                                 input logic [63:0] exp_v, input logic [63:0] act_v);
    errors++;
    $display("ERR %s %s expected %h actual %h", name, field, exp_v, act_v);
  endtask

  task automatic print_counts();
    $display("icache returns %0d of %0d acked, dcache returns %0d of %0d acked, errors %0d",
             ic_rtrn_cnt, ic_acked, dc_rtrn_cnt, dc_acked, errors);
  endtask

  task automatic load_stimulus();
    int n;
    int c;
    for (int i = 0; i < STIM_COLS * MAX_TRANS; i++) begin
      stim_raw[i] = '1;
    end
    $readmemh("verif/adapter_stimulus.txt", stim_raw);
    n = 0;
    while (n < MAX_TRANS && stim_raw[STIM_COLS*n] < 64'd4) begin
      c = STIM_COLS * n;
      stim[n].idx     = 8'(n);
      stim[n].op      = stim_raw[c][1:0];
      stim[n].addr    = stim_raw[c+1][PLEN-1:0];
      stim[n].size    = stim_raw[c+2][2:0];
      stim[n].tid     = stim_raw[c+3][TID_WIDTH-1:0];
      stim[n].data    = stim_raw[c+4];
      stim[n].exp_val = stim_raw[c+5];
      n++;
    end
    n_trans = n;
  endtask

  ////////////////////
  // cache drivers
  ////////////////////
  task automatic drive_icache();
    trans_t t;
    for (int i = 0; i < n_trans; i++) begin
      t = stim[i];
      if (t.op == OP_IFILL || t.op == OP_IFETCH) begin
        icache_req_i        = 1'b1;
        icache_data_i.paddr = t.addr;
        icache_data_i.nc    = (t.op == OP_IFETCH);
        icache_data_i.tid   = t.tid;
        @(posedge clk_i);
        while (!icache_ack_o) @(posedge clk_i);
        ic_acked++;
        ic_q.push_back(t);
        ic_rd_q.push_back(t);
        @(negedge clk_i);
      end
    end
    icache_req_i = 1'b0;
  endtask

  task automatic drive_dcache();
    trans_t t;
    for (int i = 0; i < n_trans; i++) begin
      t = stim[i];
      if (t.op == OP_DLOAD || t.op == OP_DSTORE) begin
        dcache_req_i        = 1'b1;
        dcache_data_i.rtype = (t.op == OP_DSTORE) ? DCACHE_STORE_REQ : DCACHE_LOAD_REQ;
        dcache_data_i.paddr = t.addr;
        dcache_data_i.size  = t.size;
        dcache_data_i.tid   = t.tid;
        dcache_data_i.data  = t.data;
        @(posedge clk_i);
        while (!dcache_ack_o) @(posedge clk_i);
        dc_acked++;
        if (t.op == OP_DSTORE) begin
          st_bus_q.push_back(t);
          st_ack_q.push_back(t);
        end else begin
          ld_q.push_back(t);
          dc_rd_q.push_back(t);
        end
        @(negedge clk_i);
      end
    end
    dcache_req_i = 1'b0;
  endtask

  ////////////////////
  // bus memory model
  ////////////////////
  // grants after 0 to 3 idle cycles, beats and write responses in order
  always @(negedge clk_i) begin
    bus_rd_gnt_i = 1'b0;
    bus_wr_gnt_i = 1'b0;
    if (bus_rd_req_o || bus_wr_req_o) begin
      if (gnt_wait == 0) begin
        bus_rd_gnt_i = bus_rd_req_o;
        bus_wr_gnt_i = bus_wr_req_o;
        draw_bits(2, gnt_wait);
      end else begin
        gnt_wait--;
      end
    end
    bus_rd_valid_i = 1'b0;
    if (rd_q.size() != 0) begin
      bus_rd_valid_i     = 1'b1;
      bus_rd_beat_i.data = mem_word(rd_q[0].addr + PLEN'(8 * beat_cnt));
      bus_rd_beat_i.id   = rd_q[0].id;
      bus_rd_beat_i.last = (beat_cnt == int'(rd_q[0].blen));
      if (bus_rd_beat_i.last) begin
        void'(rd_q.pop_front());
        beat_cnt = 0;
      end else begin
        beat_cnt++;
      end
    end
    bus_b_valid_i = (b_q.size() != 0);
    if (bus_b_valid_i) begin
      bus_b_id_i = b_q[0];
    end
  end

  ////////////////////
  // checkers
  ////////////////////
  task automatic check_read();
    trans_t                t;
    logic                  found;
    logic [BLEN_WIDTH-1:0] exp_blen;
    logic [1:0]            exp_size;
    found = 1'b0;
    if (bus_rd_o.id == BUS_ID_ICACHE && ic_rd_q.size() != 0) begin
      t        = ic_rd_q.pop_front();
      found    = 1'b1;
      exp_blen = (t.op == OP_IFILL) ? BLEN_WIDTH'(ICACHE_LINE_WORDS - 1) : '0;
      exp_size = 2'b11;
    end else if (bus_rd_o.id == BUS_ID_DCACHE && dc_rd_q.size() != 0) begin
      t        = dc_rd_q.pop_front();
      found    = 1'b1;
      exp_blen = t.size[2] ? BLEN_WIDTH'(DCACHE_LINE_WORDS - 1) : '0;
      exp_size = t.size[1:0];
    end
    if (!found) begin
      errors++;
      $display("bus read to %h seen with no read outstanding", bus_rd_o.addr);
    end else begin
      if (bus_rd_o.addr !== t.addr) report_mismatch(test_name(t), "rd_addr", t.addr,
                                                    bus_rd_o.addr);
      if (bus_rd_o.blen !== exp_blen) report_mismatch(test_name(t), "blen", exp_blen,
                                                      bus_rd_o.blen);
      if (bus_rd_o.size !== exp_size) report_mismatch(test_name(t), "rd_size", exp_size,
                                                      bus_rd_o.size);
    end
  endtask

  task automatic check_write();
    trans_t t;
    if (st_bus_q.size() == 0) begin
      errors++;
      $display("bus write to %h seen with no store outstanding", bus_wr_o.addr);
    end else begin
      t = st_bus_q.pop_front();
      if (bus_wr_o.addr !== t.addr) report_mismatch(test_name(t), "addr", t.addr, bus_wr_o.addr);
      if (bus_wr_o.data !== t.data) report_mismatch(test_name(t), "data", t.data, bus_wr_o.data);
      if (bus_wr_o.be !== t.exp_val[7:0]) begin
        report_mismatch(test_name(t), "be", t.exp_val, bus_wr_o.be);
      end
    end
    b_q.push_back(bus_wr_o.id);
  endtask

  task automatic check_icache_return();
    trans_t t;
    ic_rtrn_cnt++;
    if (ic_q.size() == 0) begin
      errors++;
      $display("icache return arrived with no fetch outstanding");
    end else begin
      t = ic_q.pop_front();
      if (icache_rtrn_o.tid !== t.tid) report_mismatch(test_name(t), "tid", t.tid,
                                                       icache_rtrn_o.tid);
      if (icache_rtrn_o.data[0] !== t.exp_val) report_mismatch(test_name(t), "word0",
                                                               t.exp_val, icache_rtrn_o.data[0]);
      if (t.op == OP_IFILL) begin
        for (int k = 1; k < ICACHE_LINE_WORDS; k++) begin
          if (icache_rtrn_o.data[k] !== mem_word(t.addr + PLEN'(8 * k))) begin
            report_mismatch(test_name(t), $sformatf("word%0d", k),
                            mem_word(t.addr + PLEN'(8 * k)), icache_rtrn_o.data[k]);
          end
        end
      end
    end
  endtask

  task automatic check_dcache_return();
    trans_t t;
    dc_rtrn_cnt++;
    if (dcache_rtrn_o.rtype == DCACHE_STORE_ACK && st_ack_q.size() != 0) begin
      t = st_ack_q.pop_front();
      if (dcache_rtrn_o.tid !== t.tid) report_mismatch(test_name(t), "tid", t.tid,
                                                       dcache_rtrn_o.tid);
    end else if (dcache_rtrn_o.rtype == DCACHE_LOAD_ACK && ld_q.size() != 0) begin
      t = ld_q.pop_front();
      if (dcache_rtrn_o.tid !== t.tid) report_mismatch(test_name(t), "tid", t.tid,
                                                       dcache_rtrn_o.tid);
      if (dcache_rtrn_o.data[0] !== t.exp_val) report_mismatch(test_name(t), "word0",
                                                               t.exp_val, dcache_rtrn_o.data[0]);
      if (t.size[2] && dcache_rtrn_o.data[1] !== mem_word(t.addr + PLEN'(8))) begin
        report_mismatch(test_name(t), "word1", mem_word(t.addr + PLEN'(8)),
                        dcache_rtrn_o.data[1]);
      end
    end else begin
      errors++;
      $display("dcache return of type %0d arrived with none outstanding", dcache_rtrn_o.rtype);
    end
  endtask

  // bus handshakes and cache returns, sampled at the rising edge
  always @(posedge clk_i) begin
    if (icache_rtrn_vld_o !== ic_last_q) begin
      errors++;
      $display("icache return pulse not one cycle after its last read beat");
    end
    if (dc_last_q && !(dcache_rtrn_vld_o && dcache_rtrn_o.rtype == DCACHE_LOAD_ACK)) begin
      errors++;
      $display("dcache load return missing one cycle after its last read beat");
    end
    ic_last_q = bus_rd_valid_i && bus_rd_beat_i.last && (bus_rd_beat_i.id == BUS_ID_ICACHE);
    dc_last_q = bus_rd_valid_i && bus_rd_beat_i.last && (bus_rd_beat_i.id == BUS_ID_DCACHE);
    if (bus_rd_req_o && bus_rd_gnt_i) begin
      check_read();
      rd_q.push_back(bus_rd_o);
    end
    if (bus_wr_req_o && bus_wr_gnt_i) check_write();
    if (bus_b_valid_i && bus_b_ready_o) void'(b_q.pop_front());
    if (icache_rtrn_vld_o) check_icache_return();
    if (dcache_rtrn_vld_o) check_dcache_return();
  end

  ////////////////////
  // main sequence
  ////////////////////
  initial begin
    load_stimulus();
    if (n_trans == 0) begin
      errors++;
      $display("no transactions could be read from verif/adapter_stimulus.txt");
    end
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    @(posedge clk_i);
    if (icache_rtrn_vld_o !== 1'b0) report_mismatch("reset", "ic_vld", 0, icache_rtrn_vld_o);
    if (dcache_rtrn_vld_o !== 1'b0) report_mismatch("reset", "dc_vld", 0, dcache_rtrn_vld_o);
    if (bus_rd_req_o !== 1'b0) report_mismatch("reset", "rd_req", 0, bus_rd_req_o);
    if (bus_wr_req_o !== 1'b0) report_mismatch("reset", "wr_req", 0, bus_wr_req_o);
    @(negedge clk_i);
    fork
      drive_icache();
      drive_dcache();
    join
    while (ic_q.size() != 0 || ld_q.size() != 0 || st_ack_q.size() != 0) @(posedge clk_i);
    // idle time to catch late duplicate returns
    repeat (20) @(posedge clk_i);
    if (ic_rtrn_cnt != ic_acked) report_mismatch("count", "icache", ic_acked, ic_rtrn_cnt);
    if (dc_rtrn_cnt != dc_acked) report_mismatch("count", "dcache", dc_acked, dc_rtrn_cnt);
    print_counts();
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (n_trans > 0);
    repeat (n_trans * 200) @(posedge clk_i);
    $display("timeout: returns still missing after %0d cycles", n_trans * 200);
    print_counts();
    $display("tests failed");
    $finish;
  end

endmodule

// ==== verif/adapter_stimulus.txt ====
// columns: op addr size tid store_data expect, all hex
// op 0 line fill, 1 uncached fetch, 2 load, 3 store; expect is word 0, or the byte enable
0 00001000 3 0 0000000000000000 00001000ffffefff
2 80000000 7 0 0000000000000000 800000007fffffff
3 10000008 3 1 0123456789abcdef 00000000000000ff
1 00002008 3 1 0000000000000000 00002008ffffdff7
2 80000018 3 2 0000000000000000 800000187fffffe7
0 00001020 3 2 0000000000000000 00001020ffffefdf
3 10000014 2 3 deadbeef00000000 00000000000000f0
1 0000200c 3 3 0000000000000000 00002008ffffdff7
2 80000040 7 0 0000000000000000 800000407fffffbf
2 80000104 2 1 0000000000000000 800001007ffffeff
0 00001040 3 0 0000000000000000 00001040ffffefbf
3 10000022 1 2 00000000a5a50000 000000000000000c
3 10000037 0 3 5a00000000000000 0000000000000080
0 00003000 3 1 0000000000000000 00003000ffffcfff
2 80000203 0 0 0000000000000000 800002007ffffdff
1 00003104 3 2 0000000000000000 00003100ffffceff
2 80000300 7 1 0000000000000000 800003007ffffcff
3 10000041 0 2 000000000000c300 0000000000000002
0 00001060 3 3 0000000000000000 00001060ffffef9f
2 80000408 3 3 0000000000000000 800004087ffffbf7
3 10000056 1 0 1234000000000000 00000000000000c0
0 00004000 3 0 0000000000000000 00004000ffffbfff
2 80000500 7 1 0000000000000000 800005007ffffaff
1 00004010 3 1 0000000000000000 00004010ffffbfef
3 10000060 2 2 00000000cafef00d 000000000000000f
2 80000606 1 3 0000000000000000 800006007ffff9ff

// ==== cache_bus_adapter.f ====
common/cache_bus_pkg.sv
verilog/id_fifo.sv
icache_path/icache_path.sv
dcache_path/dcache_path.sv
verilog/bus_arbiter.sv
verilog/cache_bus_adapter.sv
verif/tb_cache_bus_adapter.sv

// ==== run.sh ====
#!/bin/sh
# build the cache bus adapter testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f cache_bus_adapter.f \
  --top-module tb_cache_bus_adapter -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "all tests passed" &&
echo "PASS" && exit 0 ||
echo "FAIL" && exit 1
